// ==== Bender.yml ====
package:
  name: ddr2_cpu_interface

sources:
  - include_dirs:
      - source
    files:
      - source/ddr2_ctrl_pkg.sv
      - source/ddr2_win_if.sv
      - source/ddr2_win_regs.sv
      - source/ddr2_cmd_seq.sv
      - source/ddr2_cpu_interface.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/ddr2_cpu_interface_properties.sv
      - tests/ddr2_cpu_interface_checker.sv
      - tests/ddr2_cpu_interface_tb.sv

// ==== files.f ====
+incdir+source
source/ddr2_ctrl_pkg.sv
source/ddr2_win_if.sv
source/ddr2_win_regs.sv
source/ddr2_cmd_seq.sv
source/ddr2_cpu_interface.sv
tests/ddr2_cpu_interface_properties.sv
tests/ddr2_cpu_interface_checker.sv
tests/ddr2_cpu_interface_tb.sv

// ==== source/ddr2_cmd_seq.sv ====
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_cmd_seq
  import ddr2_ctrl_pkg::*;
(
  input  logic                   ddr_clk_0,
  input  logic                   wb_rst_i,
  ddr2_win_if.seq                win,
  output ddr2_cmd_e              af_cmnd_o,
  output ddr2_addr_t             af_addr_o,
  output logic                   af_wen_o,
  output ddr2_beat_t             df_data_o,
  output logic [`DDR2_MASK_W-1:0] df_mask_o,
  output logic                   df_wen_o,
  input  logic                   af_afull_i,
  input  logic                   df_afull_i,
  input  ddr2_beat_t             rd_data_i,
  input  logic                   rd_dvalid_i
);

  seq_state_e state;
  // write started while a fifo was almost full
  logic       wr_pend;
  // 0 waits for the low beat, 1 for the high beat
  logic       rd_beat;
  // both fifos can take a full write
  logic       fifo_room;

  assign fifo_room = ~af_afull_i & ~df_afull_i;

  always_ff @(posedge ddr_clk_0) begin
    if (wb_rst_i) begin
      state       <= SEQ_IDLE;
      wr_pend     <= 1'b0;
      rd_beat     <= 1'b0;
      win.wr_done <= 1'b0;
      win.rd_done <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (win.wr_go) begin
            win.wr_done <= 1'b0;
          end
          if (win.wr_go || wr_pend) begin
            // hold the write until both fifos have room
            if (fifo_room) begin
              wr_pend <= 1'b0;
              state   <= SEQ_WR_BEAT0;
            end else begin
              wr_pend <= 1'b1;
            end
          end else if (win.rd_go) begin
            win.rd_done <= 1'b0;
            rd_beat     <= 1'b0;
            state       <= SEQ_RD_ISSUE;
          end
        end
        // no almost full check, a started write always sends both beats
        SEQ_WR_BEAT0: begin
          state <= SEQ_WR_BEAT1;
        end
        SEQ_WR_BEAT1: begin
          win.wr_done <= 1'b1;
          state       <= SEQ_IDLE;
        end
        SEQ_RD_ISSUE: begin
          // command goes out in the cycle af has room
          if (!af_afull_i) begin
            state <= SEQ_RD_COLLECT;
          end
        end
        SEQ_RD_COLLECT: begin
          if (rd_dvalid_i) begin
            rd_beat <= ~rd_beat;
            if (rd_beat) begin
              win.rd_done <= 1'b1;
              state       <= SEQ_IDLE;
            end
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  // returned beats, low half first
  always_ff @(posedge ddr_clk_0) begin
    if (state == SEQ_RD_COLLECT && rd_dvalid_i) begin
      if (rd_beat) begin
        win.rd_line[`DDR2_LINE_W-1:`DDR2_BEAT_W] <= rd_data_i;
      end else begin
        win.rd_line[`DDR2_BEAT_W-1:0] <= rd_data_i;
      end
    end
  end

  // address fifo, one command per operation
  assign af_cmnd_o = (state == SEQ_RD_ISSUE) ? DDR2_CMD_READ : DDR2_CMD_WRITE;
  assign af_addr_o = win.line_addr;
  assign af_wen_o  = (state == SEQ_WR_BEAT0) |
                     ((state == SEQ_RD_ISSUE) & ~af_afull_i);

  // data fifo, beat halves steered by state
  assign df_wen_o  = (state == SEQ_WR_BEAT0) | (state == SEQ_WR_BEAT1);
  assign df_data_o = (state == SEQ_WR_BEAT1) ?
                     win.wr_line[`DDR2_LINE_W-1:`DDR2_BEAT_W] :
                     win.wr_line[`DDR2_BEAT_W-1:0];
  assign df_mask_o = (state == SEQ_WR_BEAT1) ?
                     win.line_mask[2*`DDR2_MASK_W-1:`DDR2_MASK_W] :
                     win.line_mask[`DDR2_MASK_W-1:0];

endmodule

// ==== source/ddr2_cpu_interface.sv ====
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_cpu_interface (
  input  logic                    ddr_clk_0,
  input  logic                    wb_rst_i,
  // wishbone slave, window access
  input  logic                    mem_wb_cyc_i,
  input  logic                    mem_wb_stb_i,
  input  logic                    mem_wb_we_i,
  // byte selects unused, every access is a whole word
  input  logic [1:0]              mem_wb_sel_i,
  input  logic [31:0]             mem_wb_adr_i,
  input  logic [`WB_DAT_W-1:0]    mem_wb_dat_i,
  output logic [`WB_DAT_W-1:0]    mem_wb_dat_o,
  output logic                    mem_wb_ack_o,
  // ddr2 address fifo
  output logic [`DDR2_CMD_W-1:0]  ddr2_af_cmnd_o,
  output logic [`DDR2_ADDR_W-1:0] ddr2_af_addr_o,
  output logic                    ddr2_af_wen_o,
  input  logic                    ddr2_af_afull_i,
  // ddr2 data fifo
  output logic [`DDR2_BEAT_W-1:0] ddr2_df_data_o,
  output logic [`DDR2_MASK_W-1:0] ddr2_df_mask_o,
  output logic                    ddr2_df_wen_o,
  input  logic                    ddr2_df_afull_i,
  // read return
  input  logic [`DDR2_BEAT_W-1:0] ddr2_data_i,
  input  logic                    ddr2_dvalid_i
);

  // window registers to sequencer
  ddr2_win_if win ();

  ddr2_win_regs i_ddr2_win_regs (
    .ddr_clk_0 (ddr_clk_0),
    .wb_rst_i  (wb_rst_i),
    .wb_cyc_i  (mem_wb_cyc_i),
    .wb_stb_i  (mem_wb_stb_i),
    .wb_we_i   (mem_wb_we_i),
    .wb_adr_i  (mem_wb_adr_i),
    .wb_dat_i  (mem_wb_dat_i),
    .wb_dat_o  (mem_wb_dat_o),
    .wb_ack_o  (mem_wb_ack_o),
    .win       (win.regs)
  );

  ddr2_cmd_seq i_ddr2_cmd_seq (
    .ddr_clk_0   (ddr_clk_0),
    .wb_rst_i    (wb_rst_i),
    .win         (win.seq),
    .af_cmnd_o   (ddr2_af_cmnd_o),
    .af_addr_o   (ddr2_af_addr_o),
    .af_wen_o    (ddr2_af_wen_o),
    .df_data_o   (ddr2_df_data_o),
    .df_mask_o   (ddr2_df_mask_o),
    .df_wen_o    (ddr2_df_wen_o),
    .af_afull_i  (ddr2_af_afull_i),
    .df_afull_i  (ddr2_df_afull_i),
    .rd_data_i   (ddr2_data_i),
    .rd_dvalid_i (ddr2_dvalid_i)
  );

endmodule

// ==== source/ddr2_ctrl_consts.svh ====
`ifndef DDR2_CTRL_CONSTS_SVH
`define DDR2_CTRL_CONSTS_SVH

// ddr2 fifo port widths
`define DDR2_ADDR_W 31
`define DDR2_BEAT_W 128
// one line is two beats
`define DDR2_LINE_W 256
// byte mask bits per beat
`define DDR2_MASK_W 16
`define DDR2_CMD_W 3

// wishbone word width
`define WB_DAT_W 16

// window word offsets, adr bits 7 to 1
`define WIN_OFS_WR_CTRL 0
`define WIN_OFS_RD_CTRL 1
// two words each, low half first
`define WIN_OFS_ADDR 2
`define WIN_OFS_MASK 4
// sixteen words each, word 0 holds line bits 15..0
`define WIN_OFS_WR_DATA 6
`define WIN_OFS_RD_DATA 22
`define WIN_LINE_WORDS 16

`endif

// ==== source/ddr2_ctrl_pkg.sv ====
`include "ddr2_ctrl_consts.svh"

package ddr2_ctrl_pkg;

  // line address as sent on the address fifo
  typedef logic [`DDR2_ADDR_W-1:0] ddr2_addr_t;

  // full line and one fifo beat
  typedef logic [`DDR2_LINE_W-1:0] ddr2_line_t;
  typedef logic [`DDR2_BEAT_W-1:0] ddr2_beat_t;

  // mask for both beats, low beat in bits 15..0
  typedef logic [2*`DDR2_MASK_W-1:0] ddr2_line_mask_t;

  // address fifo command codes
  typedef enum logic [`DDR2_CMD_W-1:0] {
    DDR2_CMD_WRITE = 3'd0,
    DDR2_CMD_READ  = 3'd1
  } ddr2_cmd_e;

  // sequencer states
  // write beats take one cycle each
  // read issue waits on af almost full
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_WR_BEAT0,
    SEQ_WR_BEAT1,
    SEQ_RD_ISSUE,
    SEQ_RD_COLLECT
  } seq_state_e;

endpackage

// ==== source/ddr2_win_if.sv ====
`timescale 1ns/1ps

interface ddr2_win_if
  import ddr2_ctrl_pkg::*;
();

  // host side line request
  ddr2_addr_t      line_addr;
  ddr2_line_mask_t line_mask;
  ddr2_line_t      wr_line;
  // single cycle start pulses
  logic            wr_go;
  logic            rd_go;

  // sequencer results
  ddr2_line_t      rd_line;
  logic            wr_done;
  logic            rd_done;

  // register window
  modport regs (
    output line_addr, line_mask, wr_line, wr_go, rd_go,
    input  rd_line, wr_done, rd_done
  );

  // command sequencer
  modport seq (
    input  line_addr, line_mask, wr_line, wr_go, rd_go,
    output rd_line, wr_done, rd_done
  );

endinterface

// ==== source/ddr2_win_regs.sv ====
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_win_regs (
  input  logic                 ddr_clk_0,
  input  logic                 wb_rst_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [31:0]          wb_adr_i,
  input  logic [`WB_DAT_W-1:0] wb_dat_i,
  output logic [`WB_DAT_W-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  ddr2_win_if.regs             win
);

  // word offset within the window
  logic [6:0]           word_ofs;
  // new access, not yet acked
  logic                 access;
  // word index inside the write and read lines
  logic [3:0]           wr_idx;
  logic [3:0]           rd_idx;
  logic                 in_wr_data;
  logic                 in_rd_data;
  // control word written, go follows one cycle later
  logic                 wr_start_q;
  logic                 rd_start_q;
  logic [`WB_DAT_W-1:0] read_word;

  assign word_ofs = wb_adr_i[7:1];
  assign access   = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  // truncation keeps the low four bits of the relative offset
  assign wr_idx = 4'(word_ofs - 7'(`WIN_OFS_WR_DATA));
  assign rd_idx = 4'(word_ofs - 7'(`WIN_OFS_RD_DATA));

  assign in_wr_data = (word_ofs >= `WIN_OFS_WR_DATA) &&
                      (word_ofs < `WIN_OFS_WR_DATA + `WIN_LINE_WORDS);
  assign in_rd_data = (word_ofs >= `WIN_OFS_RD_DATA) &&
                      (word_ofs < `WIN_OFS_RD_DATA + `WIN_LINE_WORDS);

  // ack for one cycle, so a held strobe is served every other cycle
  always_ff @(posedge ddr_clk_0) begin
    if (wb_rst_i) begin
      wb_ack_o   <= 1'b0;
      wr_start_q <= 1'b0;
      rd_start_q <= 1'b0;
      win.wr_go  <= 1'b0;
      win.rd_go  <= 1'b0;
    end else begin
      wb_ack_o   <= access;
      // any value written to a control word starts the operation
      wr_start_q <= access & wb_we_i & (word_ofs == `WIN_OFS_WR_CTRL);
      rd_start_q <= access & wb_we_i & (word_ofs == `WIN_OFS_RD_CTRL);
      // go pulses in the cycle after ack
      win.wr_go  <= wr_start_q;
      win.rd_go  <= rd_start_q;
    end
  end

  // host writes to address, mask and write line
  // read data words take the write and drop it
  always_ff @(posedge ddr_clk_0) begin
    if (access && wb_we_i) begin
      case (word_ofs)
        `WIN_OFS_ADDR: begin
          win.line_addr[15:0] <= wb_dat_i;
        end
        `WIN_OFS_ADDR + 1: begin
          // top bit of the word has no address bit behind it
          win.line_addr[`DDR2_ADDR_W-1:16] <= wb_dat_i[`DDR2_ADDR_W-17:0];
        end
        `WIN_OFS_MASK: begin
          win.line_mask[15:0] <= wb_dat_i;
        end
        `WIN_OFS_MASK + 1: begin
          win.line_mask[31:16] <= wb_dat_i;
        end
        default: begin
          if (in_wr_data) begin
            win.wr_line[wr_idx*`WB_DAT_W +: `WB_DAT_W] <= wb_dat_i;
          end
        end
      endcase
    end
  end

  // read back mux
  always_comb begin
    read_word = '0;
    case (word_ofs)
      // done flag in bit 0
      `WIN_OFS_WR_CTRL: read_word[0] = win.wr_done;
      `WIN_OFS_RD_CTRL: read_word[0] = win.rd_done;
      `WIN_OFS_ADDR: read_word = win.line_addr[15:0];
      `WIN_OFS_ADDR + 1: begin
        read_word[`DDR2_ADDR_W-17:0] = win.line_addr[`DDR2_ADDR_W-1:16];
      end
      `WIN_OFS_MASK: read_word = win.line_mask[15:0];
      `WIN_OFS_MASK + 1: read_word = win.line_mask[31:16];
      default: begin
        if (in_wr_data) begin
          read_word = win.wr_line[wr_idx*`WB_DAT_W +: `WB_DAT_W];
        end else if (in_rd_data) begin
          read_word = win.rd_line[rd_idx*`WB_DAT_W +: `WB_DAT_W];
        end
      end
    endcase
  end

  // read data valid together with ack
  always_ff @(posedge ddr_clk_0) begin
    if (access && !wb_we_i) begin
      wb_dat_o <= read_word;
    end
  end

endmodule

// ==== tests/ddr2_cpu_interface_checker.sv ====
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_cpu_interface_checker
  import ddr2_ctrl_pkg::*;
(
  input  logic                    ddr_clk_0,
  input  logic                    wb_rst_i,
  input  logic                    wb_we_i,
  input  logic [31:0]             wb_adr_i,
  input  logic [`WB_DAT_W-1:0]    wb_dat_i,
  input  logic [`WB_DAT_W-1:0]    wb_rdat_i,
  input  logic                    wb_ack_i,
  // expected read word from the stimulus table
  input  logic                    exp_en_i,
  input  logic [`WB_DAT_W-1:0]    exp_data_i,
  input  logic [`DDR2_CMD_W-1:0]  af_cmnd_i,
  input  ddr2_addr_t              af_addr_i,
  input  logic                    af_wen_i,
  input  logic                    af_afull_i,
  input  ddr2_beat_t              df_data_i,
  input  logic [`DDR2_MASK_W-1:0] df_mask_i,
  input  logic                    df_wen_i,
  input  logic                    df_afull_i,
  output int                      error_count_o
);

  // shadow of the window as the host wrote it
  ddr2_addr_t      exp_addr;
  ddr2_line_mask_t exp_mask;
  ddr2_line_t      exp_line;
  logic [6:0]      ofs;
  logic            beat1_due = 1'b0;
  logic            rst_d = 1'b0;
  // both fifos had room at the previous edge
  logic            room_d = 1'b0;
  int              wr_starts = 0;
  int              rd_starts = 0;
  int              wr_cmds = 0;
  int              rd_cmds = 0;

  initial error_count_o = 0;

  assign ofs = wb_adr_i[7:1];

  task automatic report_fail(input string msg);
    $display("Fail %0t: %s", $time, msg);
    error_count_o++;
  endtask

  // one command per start
  task automatic check_cmd_counts();
    if (wr_cmds != wr_starts || rd_cmds != rd_starts) begin
      report_fail($sformatf("%0d write and %0d read commands for %0d and %0d starts",
                            wr_cmds, rd_cmds, wr_starts, rd_starts));
    end
  endtask

  always @(posedge ddr_clk_0) begin
    // outputs must sit at reset values
    if (rst_d && (wb_ack_i !== 1'b0 || af_wen_i !== 1'b0 || df_wen_i !== 1'b0)) begin
      report_fail("ack or fifo write enable not low after reset");
    end
    rst_d = wb_rst_i;
    if (wb_rst_i) begin
      beat1_due = 1'b0;
    end else begin
      if (beat1_due) begin
        beat1_due = 1'b0;
        if (df_wen_i !== 1'b1 || af_wen_i !== 1'b0) begin
          report_fail("write beat 1 missing");
        end else if (df_data_i !== exp_line[255:128] || df_mask_i !== exp_mask[31:16]) begin
          report_fail("write beat 1 data or mask wrong");
        end
      end else if (af_wen_i && af_cmnd_i == DDR2_CMD_WRITE) begin
        wr_cmds++;
        beat1_due = 1'b1;
        if (!room_d) begin
          report_fail("write command issued while a fifo was almost full");
        end
        if (df_wen_i !== 1'b1 || af_addr_i !== exp_addr || df_data_i !== exp_line[127:0] ||
            df_mask_i !== exp_mask[15:0]) begin
          report_fail($sformatf("write beat 0 wrong at address %h", af_addr_i));
        end
      end else if (df_wen_i) begin
        report_fail("data beat without a write command");
      end
      if (af_wen_i && af_cmnd_i == DDR2_CMD_READ) begin
        rd_cmds++;
        if (af_afull_i || af_addr_i !== exp_addr) begin
          report_fail($sformatf("read command wrong at address %h", af_addr_i));
        end
      end
      // host side, shadow follows every acked write
      if (wb_ack_i && wb_we_i) begin
        case (ofs)
          `WIN_OFS_WR_CTRL: wr_starts++;
          `WIN_OFS_RD_CTRL: rd_starts++;
          `WIN_OFS_ADDR: exp_addr[15:0] = wb_dat_i;
          `WIN_OFS_ADDR + 1: exp_addr[30:16] = wb_dat_i[14:0];
          `WIN_OFS_MASK: exp_mask[15:0] = wb_dat_i;
          `WIN_OFS_MASK + 1: exp_mask[31:16] = wb_dat_i;
          default: begin
            if (ofs >= `WIN_OFS_WR_DATA && ofs < `WIN_OFS_RD_DATA) begin
              exp_line[(ofs - `WIN_OFS_WR_DATA)*16 +: 16] = wb_dat_i;
            end
          end
        endcase
      end
      if (wb_ack_i && !wb_we_i && exp_en_i && wb_rdat_i !== exp_data_i) begin
        report_fail($sformatf("word %0d read %h, expected %h", ofs, wb_rdat_i, exp_data_i));
      end
    end
    room_d = !af_afull_i && !df_afull_i;
  end

endmodule

// ==== tests/ddr2_cpu_interface_properties.sv ====
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_cpu_interface_properties
  import ddr2_ctrl_pkg::*;
(
  input logic                   ddr_clk_0,
  input logic                   wb_rst_i,
  input logic                   ack_i,
  input logic                   af_wen_i,
  input logic [`DDR2_CMD_W-1:0] af_cmnd_i,
  input logic                   af_afull_i,
  input logic                   df_afull_i,
  input logic                   df_wen_i
);

  // assertion failures so far
  int fail_count = 0;

  // ack lasts one cycle
  ack_single: assert property (@(posedge ddr_clk_0) disable iff (wb_rst_i)
    ack_i |=> !ack_i)
    else begin
      $error("wishbone ack high for two cycles");
      fail_count++;
    end

  // beat 0 rides with the command, beat 1 follows alone
  beat_pair: assert property (@(posedge ddr_clk_0) disable iff (wb_rst_i)
    (df_wen_i && af_wen_i) |=> (df_wen_i && !af_wen_i))
    else begin
      $error("second data beat missing after beat 0");
      fail_count++;
    end

  // write leaves idle only with room in both fifos
  wr_room: assert property (@(posedge ddr_clk_0) disable iff (wb_rst_i)
    (af_wen_i && af_cmnd_i == DDR2_CMD_WRITE) |-> $past(!af_afull_i && !df_afull_i))
    else begin
      $error("write command after an almost full cycle in idle");
      fail_count++;
    end

  // read command only while af has room
  rd_room: assert property (@(posedge ddr_clk_0) disable iff (wb_rst_i)
    (af_wen_i && af_cmnd_i == DDR2_CMD_READ) |-> !af_afull_i)
    else begin
      $error("read command while af almost full");
      fail_count++;
    end

endmodule

// ==== tests/ddr2_cpu_interface_tb.sv ====
`timescale 1ns/1ps
`include "ddr2_ctrl_consts.svh"

module ddr2_cpu_interface_tb
  import ddr2_ctrl_pkg::*;
();

  localparam int ACK_TIMEOUT = 20;
  localparam int DONE_POLLS  = 100;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_START_WR, OP_START_RD} tb_op_e;
  // word i of a step carries data + i*0111h, reads expect exp + i*0111h
  typedef struct {
    tb_op_e      op;
    int          ofs;
    int          cnt;
    logic [15:0] data;
    logic [15:0] exp;
  } step_t;

  logic         ddr_clk_0 = 1'b0;
  logic         wb_rst_i = 1'b1;
  logic         wb_cyc = 1'b0;
  logic         wb_stb = 1'b0;
  logic         wb_we = 1'b0;
  logic [1:0]   wb_sel = 2'b11;
  logic [31:0]  wb_adr = '0;
  logic [15:0]  wb_wdat = '0;
  logic [15:0]  wb_rdat;
  logic         wb_ack;
  logic [2:0]   af_cmnd;
  ddr2_addr_t   af_addr;
  logic         af_wen;
  logic         af_afull = 1'b0;
  ddr2_beat_t   df_data;
  logic [15:0]  df_mask;
  logic         df_wen;
  logic         df_afull = 1'b0;
  ddr2_beat_t   rd_data = '0;
  logic         rd_dvalid = 1'b0;
  logic         exp_en = 1'b0;
  logic [15:0]  exp_data = '0;
  int           error_count;
  int           assert_fails = 0;
  int           timeout_count = 0;
  logic         timed_out = 1'b0;
  integer       seed = 33782;
  step_t        steps [29];
  // memory model state
  ddr2_line_t   mem_lines [ddr2_addr_t];
  ddr2_beat_t   wr_lo;
  ddr2_addr_t   wr_addr;
  ddr2_line_t   rd_line_q;
  int           rd_beats = 0;
  int           rd_gap = 0;

  always #20 ddr_clk_0 = ~ddr_clk_0;

  ddr2_cpu_interface i_ddr2_cpu_interface (
    .ddr_clk_0 (ddr_clk_0), .wb_rst_i (wb_rst_i),
    .mem_wb_cyc_i (wb_cyc), .mem_wb_stb_i (wb_stb), .mem_wb_we_i (wb_we),
    .mem_wb_sel_i (wb_sel), .mem_wb_adr_i (wb_adr), .mem_wb_dat_i (wb_wdat),
    .mem_wb_dat_o (wb_rdat), .mem_wb_ack_o (wb_ack),
    .ddr2_af_cmnd_o (af_cmnd), .ddr2_af_addr_o (af_addr), .ddr2_af_wen_o (af_wen),
    .ddr2_af_afull_i (af_afull), .ddr2_df_data_o (df_data), .ddr2_df_mask_o (df_mask),
    .ddr2_df_wen_o (df_wen), .ddr2_df_afull_i (df_afull),
    .ddr2_data_i (rd_data), .ddr2_dvalid_i (rd_dvalid)
  );

  ddr2_cpu_interface_checker i_checker (
    .ddr_clk_0 (ddr_clk_0), .wb_rst_i (wb_rst_i), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_wdat), .wb_rdat_i (wb_rdat), .wb_ack_i (wb_ack),
    .exp_en_i (exp_en), .exp_data_i (exp_data), .af_cmnd_i (af_cmnd),
    .af_addr_i (af_addr), .af_wen_i (af_wen), .af_afull_i (af_afull),
    .df_data_i (df_data), .df_mask_i (df_mask), .df_wen_i (df_wen),
    .df_afull_i (df_afull), .error_count_o (error_count)
  );

  bind ddr2_cpu_interface ddr2_cpu_interface_properties i_properties (
    .ddr_clk_0 (ddr_clk_0), .wb_rst_i (wb_rst_i), .ack_i (mem_wb_ack_o),
    .af_wen_i (ddr2_af_wen_o), .af_cmnd_i (ddr2_af_cmnd_o), .af_afull_i (ddr2_af_afull_i),
    .df_afull_i (ddr2_df_afull_i), .df_wen_i (ddr2_df_wen_o)
  );

  // unwritten lines return a pattern built from their address
  function automatic ddr2_line_t fill_line(input ddr2_addr_t addr);
    return {8{1'b1, addr}};
  endfunction

  // memory model, samples fifo writes at the edge and answers 2 ns later
  always @(posedge ddr_clk_0) begin
    if (!wb_rst_i && df_wen && af_wen) begin
      wr_lo   = df_data;
      wr_addr = af_addr;
    end else if (!wb_rst_i && df_wen) begin
      mem_lines[wr_addr] = {df_data, wr_lo};
    end
    if (!wb_rst_i && af_wen && af_cmnd == DDR2_CMD_READ) begin
      rd_line_q = mem_lines.exists(af_addr) ? mem_lines[af_addr] : fill_line(af_addr);
      rd_beats  = 2;
      rd_gap    = {$random(seed)} % 4;
    end
    #2;
    rd_dvalid = 1'b0;
    if (rd_beats > 0 && rd_gap > 0) begin
      rd_gap--;
    end else if (rd_beats > 0) begin
      rd_data   = (rd_beats == 2) ? rd_line_q[127:0] : rd_line_q[255:128];
      rd_dvalid = 1'b1;
      rd_beats--;
    end
    // almost full roughly one cycle in four
    af_afull = !wb_rst_i && ({$random(seed)} % 4 == 0);
    df_afull = !wb_rst_i && ({$random(seed)} % 4 == 0);
  end

  // one word access, returns one idle cycle after ack
  task automatic wb_access(input logic write, input logic [6:0] ofs, input logic [15:0] wdat,
                           input logic check, input logic [15:0] exp, output logic [15:0] rd);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = write;
    wb_adr   = {24'h0, ofs, 1'b0};
    wb_wdat  = wdat;
    exp_en   = check;
    exp_data = exp;
    waited   = 0;
    @(posedge ddr_clk_0);
    while (wb_ack !== 1'b1 && waited < ACK_TIMEOUT) begin
      @(posedge ddr_clk_0);
      waited++;
    end
    rd = wb_rdat;
    if (wb_ack !== 1'b1) begin
      $display("no ack from window at word offset %0d", ofs);
      timeout_count++;
      timed_out = 1'b1;
    end
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    exp_en = 1'b0;
    @(posedge ddr_clk_0);
    #2;
  endtask

  // start, check the cleared flag, then poll until done
  task automatic start_and_wait(input logic is_read);
    logic [6:0]  ctrl;
    logic [15:0] rd;
    int          polls;
    ctrl = is_read ? 7'(`WIN_OFS_RD_CTRL) : 7'(`WIN_OFS_WR_CTRL);
    wb_access(1'b1, ctrl, 16'h0001, 1'b0, 16'h0, rd);
    // go has cleared done before this read is taken
    wb_access(1'b0, ctrl, 16'h0, 1'b1, 16'h0, rd);
    polls = 0;
    while (!timed_out && rd[0] !== 1'b1 && polls < DONE_POLLS) begin
      wb_access(1'b0, ctrl, 16'h0, 1'b0, 16'h0, rd);
      polls++;
    end
    if (!timed_out && rd[0] !== 1'b1) begin
      $display("done flag never set on control word %0d", ctrl);
      timeout_count++;
      timed_out = 1'b1;
    end else if (!timed_out) begin
      wb_access(1'b0, ctrl, 16'h0, 1'b1, 16'h0001, rd);
    end
  endtask

  task automatic apply_step(input step_t s);
    logic [15:0] rd;
    for (int i = 0; i < s.cnt && !timed_out; i++) begin
      case (s.op)
        OP_WR: wb_access(1'b1, 7'(s.ofs + i), 16'(s.data + i*16'h0111), 1'b0, 16'h0, rd);
        OP_RD: wb_access(1'b0, 7'(s.ofs + i), 16'h0, 1'b1, 16'(s.exp + i*16'h0111), rd);
        default: start_and_wait(s.op == OP_START_RD);
      endcase
    end
  endtask

  initial begin
    // op, offset, words, data, expected
    steps = '{
      '{OP_RD, `WIN_OFS_WR_CTRL, 1, 16'h0, 16'h0}, '{OP_RD, `WIN_OFS_RD_CTRL, 1, 16'h0, 16'h0},
      '{OP_WR, `WIN_OFS_ADDR, 1, 16'h1234, 16'h0}, '{OP_WR, `WIN_OFS_ADDR + 1, 1, 16'h8056, 0},
      '{OP_RD, `WIN_OFS_ADDR, 1, 16'h0, 16'h1234}, '{OP_RD, `WIN_OFS_ADDR + 1, 1, 16'h0, 16'h0056},
      '{OP_WR, `WIN_OFS_MASK, 1, 16'hffff, 16'h0}, '{OP_WR, `WIN_OFS_MASK + 1, 1, 16'h0ff0, 0},
      '{OP_RD, `WIN_OFS_MASK, 1, 16'h0, 16'hffff}, '{OP_RD, `WIN_OFS_MASK + 1, 1, 16'h0, 16'h0ff0},
      '{OP_WR, `WIN_OFS_WR_DATA, 16, 16'ha000, 0}, '{OP_RD, `WIN_OFS_WR_DATA, 16, 0, 16'ha000},
      '{OP_START_WR, 0, 1, 16'h0, 16'h0},
      // second line at another address with another mask
      '{OP_WR, `WIN_OFS_ADDR, 1, 16'h0040, 16'h0}, '{OP_WR, `WIN_OFS_ADDR + 1, 1, 16'h0002, 0},
      '{OP_WR, `WIN_OFS_MASK, 1, 16'h00ff, 16'h0}, '{OP_WR, `WIN_OFS_WR_DATA, 16, 16'h5a00, 0},
      '{OP_START_WR, 0, 1, 16'h0, 16'h0},
      // read back the first line, then try to overwrite the read words
      '{OP_WR, `WIN_OFS_ADDR, 1, 16'h1234, 16'h0}, '{OP_WR, `WIN_OFS_ADDR + 1, 1, 16'h0056, 0},
      '{OP_START_RD, 0, 1, 16'h0, 16'h0}, '{OP_RD, `WIN_OFS_RD_DATA, 16, 16'h0, 16'ha000},
      '{OP_WR, `WIN_OFS_RD_DATA, 16, 16'hc300, 0}, '{OP_RD, `WIN_OFS_RD_DATA, 16, 0, 16'ha000},
      '{OP_WR, `WIN_OFS_ADDR, 1, 16'h0040, 16'h0}, '{OP_WR, `WIN_OFS_ADDR + 1, 1, 16'h0002, 0},
      '{OP_START_RD, 0, 1, 16'h0, 16'h0}, '{OP_RD, `WIN_OFS_RD_DATA, 16, 16'h0, 16'h5a00},
      '{OP_RD, `WIN_OFS_WR_CTRL, 1, 16'h0, 16'h0001}
    };
    repeat (3) @(posedge ddr_clk_0);
    #2;
    wb_rst_i = 1'b0;
    foreach (steps[i]) begin
      if (!timed_out) begin
        apply_step(steps[i]);
      end
    end
    i_checker.check_cmd_counts();
    assert_fails = i_ddr2_cpu_interface.i_properties.fail_count;
    $display("closing: %0d check errors, %0d assertion failures, %0d timeouts",
             error_count, assert_fails, timeout_count);
    if (error_count == 0 && assert_fails == 0 && timeout_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
